// File: hw/hdu_pkg.sv
/* Hazard unit shared definitions */
`default_nettype none

package hdu_pkg;

    // architectural register file
    localparam int REG_ADDR_W = 5;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // x0 .. x31

    // execution unit that will write back the result
    localparam int EXU_TYPE_W = 2;
    typedef logic [EXU_TYPE_W-1:0] exu_type_t;

    localparam exu_type_t EXU_ALU = 2'd0;  // single cycle integer
    localparam exu_type_t EXU_MUL = 2'd1;  // pipelined multiplier
    localparam exu_type_t EXU_DIV = 2'd2;  // iterative divider
    localparam exu_type_t EXU_CSR = 2'd3;  // csr read/modify

    // in-flight long write tracking
    localparam int DEF_NUM_SLOTS = 8;

endpackage

`default_nettype wire

// File: hw/hdu_scoreboard.sv
/* Long-latency write scoreboard */
`timescale 1ns/100ps
`default_nettype none

module hdu_scoreboard #(
    parameter int NUM_SLOTS = hdu_pkg::DEF_NUM_SLOTS
) (
    input  logic                                   clk,
    input  logic                                   rst_n,

    // fills from the issue stage
    input  logic                                   wr1_en_i,
    input  logic [$clog2(NUM_SLOTS)-1:0]           wr1_id_i,
    input  hdu_pkg::reg_addr_t                     wr1_rd_i,
    input  hdu_pkg::exu_type_t                     wr1_type_i,
    input  logic                                   wr2_en_i,
    input  logic [$clog2(NUM_SLOTS)-1:0]           wr2_id_i,
    input  hdu_pkg::reg_addr_t                     wr2_rd_i,
    input  hdu_pkg::exu_type_t                     wr2_type_i,

    // clears from writeback
    input  logic                                   cmt1_valid_i,
    input  logic [$clog2(NUM_SLOTS)-1:0]           cmt1_id_i,
    input  logic                                   cmt2_valid_i,
    input  logic [$clog2(NUM_SLOTS)-1:0]           cmt2_id_i,

    output logic [NUM_SLOTS-1:0]                   slot_valid_o,
    output hdu_pkg::reg_addr_t [NUM_SLOTS-1:0]     slot_rd_o,
    output hdu_pkg::exu_type_t [NUM_SLOTS-1:0]     slot_type_o,
    output logic                                   busy_o
);

    import hdu_pkg::*;

    logic [NUM_SLOTS-1:0]      valid_q;
    logic [NUM_SLOTS-1:0]      valid_nxt;
    reg_addr_t [NUM_SLOTS-1:0] rd_q;    // destination of the pending write
    exu_type_t [NUM_SLOTS-1:0] type_q;  // unit that owns the write

    // commits clear first, issue fills land on top
    always_comb begin
        valid_nxt = valid_q;
        if (cmt1_valid_i) valid_nxt[cmt1_id_i] = 1'b0;
        if (cmt2_valid_i) valid_nxt[cmt2_id_i] = 1'b0;
        if (wr1_en_i)     valid_nxt[wr1_id_i]  = 1'b1;
        if (wr2_en_i)     valid_nxt[wr2_id_i]  = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_nxt;
        end
    end

    // entry payload, only meaningful while the valid bit is set
    always_ff @(posedge clk) begin
        if (wr1_en_i) begin
            rd_q[wr1_id_i]   <= wr1_rd_i;
            type_q[wr1_id_i] <= wr1_type_i;
        end
        if (wr2_en_i) begin
            rd_q[wr2_id_i]   <= wr2_rd_i;
            type_q[wr2_id_i] <= wr2_type_i;
        end
    end

    assign slot_valid_o = valid_q;
    assign slot_rd_o    = rd_q;
    assign slot_type_o  = type_q;
    assign busy_o       = |valid_q;  // any long write still in flight

endmodule

`default_nettype wire

// File: hw/hdu_slot_alloc.sv
/* Lowest free slot finder */
`timescale 1ns/100ps
`default_nettype none

module hdu_slot_alloc #(
    parameter int NUM_SLOTS = hdu_pkg::DEF_NUM_SLOTS
) (
    input  logic [NUM_SLOTS-1:0]         slot_valid_i,
    output logic [$clog2(NUM_SLOTS)-1:0] free_id1_o,
    output logic [$clog2(NUM_SLOTS)-1:0] free_id2_o,
    output logic                         two_free_o
);

    localparam int ID_W = $clog2(NUM_SLOTS);

    logic            found1;
    logic            found2;
    logic [ID_W-1:0] id1;
    logic [ID_W-1:0] id2;

    // single upward scan, first hit is id1, next hit is id2
    always_comb begin
        found1 = 1'b0;
        found2 = 1'b0;
        id1    = '0;
        id2    = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (!slot_valid_i[i]) begin
                if (!found1) begin
                    id1    = ID_W'(i);
                    found1 = 1'b1;
                end else if (!found2) begin
                    id2    = ID_W'(i);
                    found2 = 1'b1;
                end
            end
        end
    end

    assign free_id1_o = id1;
    assign free_id2_o = id2;
    assign two_free_o = found2;  // a second hit implies a first

endmodule

`default_nettype wire

// File: hw/hdu_hazard_check.sv
/* RAW and WAW hazard detection */
`timescale 1ns/100ps
`default_nettype none

module hdu_hazard_check #(
    parameter int NUM_SLOTS = hdu_pkg::DEF_NUM_SLOTS
) (
    // first instruction of the pair
    input  logic                               inst1_valid_i,
    input  hdu_pkg::reg_addr_t                 inst1_rd_i,
    input  hdu_pkg::reg_addr_t                 inst1_rs1_i,
    input  hdu_pkg::reg_addr_t                 inst1_rs2_i,
    input  logic                               inst1_rd_we_i,
    input  hdu_pkg::exu_type_t                 inst1_type_i,

    // second instruction of the pair
    input  logic                               inst2_valid_i,
    input  hdu_pkg::reg_addr_t                 inst2_rd_i,
    input  hdu_pkg::reg_addr_t                 inst2_rs1_i,
    input  hdu_pkg::reg_addr_t                 inst2_rs2_i,
    input  logic                               inst2_rd_we_i,
    input  hdu_pkg::exu_type_t                 inst2_type_i,

    // scoreboard state and this cycle's commits
    input  logic [NUM_SLOTS-1:0]               slot_valid_i,
    input  hdu_pkg::reg_addr_t [NUM_SLOTS-1:0] slot_rd_i,
    input  hdu_pkg::exu_type_t [NUM_SLOTS-1:0] slot_type_i,
    input  logic                               cmt1_valid_i,
    input  logic [$clog2(NUM_SLOTS)-1:0]       cmt1_id_i,
    input  logic                               cmt2_valid_i,
    input  logic [$clog2(NUM_SLOTS)-1:0]       cmt2_id_i,

    output logic                               inst1_sb_hz_o,
    output logic                               inst2_sb_hz_o,
    output logic                               inst2_dep_o,
    output logic                               inst1_writes_o,
    output logic                               inst2_writes_o
);

    import hdu_pkg::*;

    localparam int ID_W = $clog2(NUM_SLOTS);

    logic [NUM_SLOTS-1:0] slot_live;  // occupied and not retiring now
    logic [NUM_SLOTS-1:0] inst1_raw;
    logic [NUM_SLOTS-1:0] inst1_waw;
    logic [NUM_SLOTS-1:0] inst2_raw;
    logic [NUM_SLOTS-1:0] inst2_waw;

    // source checks, x0 never creates a dependency
    logic inst1_rs1_chk;
    logic inst1_rs2_chk;
    logic inst2_rs1_chk;
    logic inst2_rs2_chk;

    function automatic logic [NUM_SLOTS-1:0] raw_vec(
        input logic [NUM_SLOTS-1:0]      live,
        input reg_addr_t [NUM_SLOTS-1:0] srd,
        input logic                      rs1_chk,
        input reg_addr_t                 rs1,
        input logic                      rs2_chk,
        input reg_addr_t                 rs2
    );
        logic [NUM_SLOTS-1:0] m;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            m[s] = live[s] && ((rs1_chk && rs1 == srd[s]) || (rs2_chk && rs2 == srd[s]));
        end
        return m;
    endfunction

    // same destination only matters across different units
    function automatic logic [NUM_SLOTS-1:0] waw_vec(
        input logic [NUM_SLOTS-1:0]      live,
        input reg_addr_t [NUM_SLOTS-1:0] srd,
        input exu_type_t [NUM_SLOTS-1:0] styp,
        input logic                      writes,
        input reg_addr_t                 rd,
        input exu_type_t                 typ
    );
        logic [NUM_SLOTS-1:0] m;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            m[s] = live[s] && writes && (rd == srd[s]) && (typ != styp[s]);
        end
        return m;
    endfunction

    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_live
        assign slot_live[s] = slot_valid_i[s]
                            && !(cmt1_valid_i && cmt1_id_i == ID_W'(s))
                            && !(cmt2_valid_i && cmt2_id_i == ID_W'(s));
    end

    assign inst1_rs1_chk  = inst1_valid_i && (inst1_rs1_i != '0);
    assign inst1_rs2_chk  = inst1_valid_i && (inst1_rs2_i != '0);
    assign inst2_rs1_chk  = inst2_valid_i && (inst2_rs1_i != '0);
    assign inst2_rs2_chk  = inst2_valid_i && (inst2_rs2_i != '0);
    assign inst1_writes_o = inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != '0);
    assign inst2_writes_o = inst2_valid_i && inst2_rd_we_i && (inst2_rd_i != '0);

    assign inst1_raw = raw_vec(slot_live, slot_rd_i, inst1_rs1_chk, inst1_rs1_i,
                               inst1_rs2_chk, inst1_rs2_i);
    assign inst2_raw = raw_vec(slot_live, slot_rd_i, inst2_rs1_chk, inst2_rs1_i,
                               inst2_rs2_chk, inst2_rs2_i);
    assign inst1_waw = waw_vec(slot_live, slot_rd_i, slot_type_i, inst1_writes_o,
                               inst1_rd_i, inst1_type_i);
    assign inst2_waw = waw_vec(slot_live, slot_rd_i, slot_type_i, inst2_writes_o,
                               inst2_rd_i, inst2_type_i);

    assign inst1_sb_hz_o = |(inst1_raw | inst1_waw);
    assign inst2_sb_hz_o = |(inst2_raw | inst2_waw);

    // inst2 reads or rewrites what inst1 produces
    assign inst2_dep_o = inst1_writes_o && ((inst2_rs1_chk && inst2_rs1_i == inst1_rd_i)
                                         || (inst2_rs2_chk && inst2_rs2_i == inst1_rd_i)
                                         || (inst2_writes_o && inst2_rd_i == inst1_rd_i));

endmodule

`default_nettype wire

// File: hw/hdu_issue_ctrl.sv
/* Dual issue decision */
`timescale 1ns/100ps
`default_nettype none

module hdu_issue_ctrl (
    input  logic       two_free_i,
    input  logic       irq_req_i,
    input  logic       inst1_jump_i,
    input  logic       inst1_branch_i,
    input  logic       inst1_sb_hz_i,
    input  logic       inst2_sb_hz_i,
    input  logic       inst2_dep_i,
    output logic [1:0] issue_o  // bit0 inst1, bit1 inst2
);

    localparam logic [1:0] ISSUE_NONE = 2'b00;
    localparam logic [1:0] ISSUE_ONE  = 2'b01;
    localparam logic [1:0] ISSUE_BOTH = 2'b11;

    always_comb begin
        if (!two_free_i) begin
            issue_o = ISSUE_NONE;  // no room for a pair of ids
        end else if (irq_req_i) begin
            issue_o = ISSUE_NONE;  // let the interrupt take the pipe
        end else if (inst1_sb_hz_i) begin
            issue_o = ISSUE_NONE;
        end else if (inst1_jump_i || inst1_branch_i) begin
            // control flow goes alone
            issue_o = ISSUE_ONE;
        end else if (inst2_sb_hz_i || inst2_dep_i) begin
            issue_o = ISSUE_ONE;   // inst2 waits for the next cycle
        end else begin
            issue_o = ISSUE_BOTH;
        end
    end

endmodule

`default_nettype wire

// File: hw/hdu_top.sv
/* Dual issue hazard detection unit */
`timescale 1ns/100ps
`default_nettype none

module hdu_top #(
    parameter int NUM_SLOTS = hdu_pkg::DEF_NUM_SLOTS
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         inst1_valid_i,
    input  hdu_pkg::reg_addr_t           inst1_rd_i,
    input  hdu_pkg::reg_addr_t           inst1_rs1_i,
    input  hdu_pkg::reg_addr_t           inst1_rs2_i,
    input  logic                         inst1_rd_we_i,
    input  hdu_pkg::exu_type_t           inst1_exu_type_i,

    input  logic                         inst2_valid_i,
    input  hdu_pkg::reg_addr_t           inst2_rd_i,
    input  hdu_pkg::reg_addr_t           inst2_rs1_i,
    input  hdu_pkg::reg_addr_t           inst2_rs2_i,
    input  logic                         inst2_rd_we_i,
    input  hdu_pkg::exu_type_t           inst2_exu_type_i,

    // writeback of finished long writes
    input  logic                         commit1_valid_i,
    input  logic [$clog2(NUM_SLOTS)-1:0] commit1_id_i,
    input  logic                         commit2_valid_i,
    input  logic [$clog2(NUM_SLOTS)-1:0] commit2_id_i,

    input  logic                         inst1_jump_i,
    input  logic                         inst1_branch_i,
    input  logic                         irq_req_i,

    output logic [1:0]                   issue_o,
    output logic [$clog2(NUM_SLOTS)-1:0] inst1_commit_id_o,
    output logic [$clog2(NUM_SLOTS)-1:0] inst2_commit_id_o,
    output logic                         long_busy_o
);

    import hdu_pkg::*;

    localparam int ID_W = $clog2(NUM_SLOTS);

    logic [NUM_SLOTS-1:0]      slot_valid;
    reg_addr_t [NUM_SLOTS-1:0] slot_rd;
    exu_type_t [NUM_SLOTS-1:0] slot_type;
    logic [ID_W-1:0]           free_id1;
    logic [ID_W-1:0]           free_id2;
    logic                      two_free;
    logic                      hz1_sb;
    logic                      hz2_sb;
    logic                      hz2_on_1;
    logic                      inst1_writes;
    logic                      inst2_writes;
    logic                      wr1_en;
    logic                      wr2_en;

    hdu_scoreboard #(.NUM_SLOTS(NUM_SLOTS)) u_scoreboard (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr1_en_i     (wr1_en),
        .wr1_id_i     (inst1_commit_id_o),
        .wr1_rd_i     (inst1_rd_i),
        .wr1_type_i   (inst1_exu_type_i),
        .wr2_en_i     (wr2_en),
        .wr2_id_i     (inst2_commit_id_o),
        .wr2_rd_i     (inst2_rd_i),
        .wr2_type_i   (inst2_exu_type_i),
        .cmt1_valid_i (commit1_valid_i),
        .cmt1_id_i    (commit1_id_i),
        .cmt2_valid_i (commit2_valid_i),
        .cmt2_id_i    (commit2_id_i),
        .slot_valid_o (slot_valid),
        .slot_rd_o    (slot_rd),
        .slot_type_o  (slot_type),
        .busy_o       (long_busy_o)
    );

    hdu_slot_alloc #(.NUM_SLOTS(NUM_SLOTS)) u_slot_alloc (
        .slot_valid_i (slot_valid),
        .free_id1_o   (free_id1),
        .free_id2_o   (free_id2),
        .two_free_o   (two_free)
    );

    hdu_hazard_check #(.NUM_SLOTS(NUM_SLOTS)) u_hazard_check (
        .inst1_valid_i  (inst1_valid_i),
        .inst1_rd_i     (inst1_rd_i),
        .inst1_rs1_i    (inst1_rs1_i),
        .inst1_rs2_i    (inst1_rs2_i),
        .inst1_rd_we_i  (inst1_rd_we_i),
        .inst1_type_i   (inst1_exu_type_i),
        .inst2_valid_i  (inst2_valid_i),
        .inst2_rd_i     (inst2_rd_i),
        .inst2_rs1_i    (inst2_rs1_i),
        .inst2_rs2_i    (inst2_rs2_i),
        .inst2_rd_we_i  (inst2_rd_we_i),
        .inst2_type_i   (inst2_exu_type_i),
        .slot_valid_i   (slot_valid),
        .slot_rd_i      (slot_rd),
        .slot_type_i    (slot_type),
        .cmt1_valid_i   (commit1_valid_i),
        .cmt1_id_i      (commit1_id_i),
        .cmt2_valid_i   (commit2_valid_i),
        .cmt2_id_i      (commit2_id_i),
        .inst1_sb_hz_o  (hz1_sb),
        .inst2_sb_hz_o  (hz2_sb),
        .inst2_dep_o    (hz2_on_1),
        .inst1_writes_o (inst1_writes),
        .inst2_writes_o (inst2_writes)
    );

    hdu_issue_ctrl u_issue_ctrl (
        .two_free_i     (two_free),
        .irq_req_i      (irq_req_i),
        .inst1_jump_i   (inst1_jump_i),
        .inst1_branch_i (inst1_branch_i),
        .inst1_sb_hz_i  (hz1_sb),
        .inst2_sb_hz_i  (hz2_sb),
        .inst2_dep_i    (hz2_on_1),
        .issue_o        (issue_o)
    );

    // ids only leave for instructions that actually issue
    assign inst1_commit_id_o = (issue_o[0] && inst1_valid_i) ? free_id1 : '0;
    assign inst2_commit_id_o = (issue_o[1] && inst2_valid_i) ? free_id2 : '0;

    // only issued writers occupy their slot
    assign wr1_en = inst1_writes && issue_o[0];
    assign wr2_en = inst2_writes && issue_o[1];

endmodule

`default_nettype wire

// File: tb/tb_hdu.sv
/* Hazard unit testbench */
`timescale 1ns/100ps
`default_nettype none

module tb_hdu;

    import hdu_pkg::*;

    localparam int  NUM_SLOTS   = 8;
    localparam int  ID_W        = $clog2(NUM_SLOTS);
    localparam real CLK_PERIOD  = 4.0;
    localparam int  RST_CYCLES  = 16;
    localparam int  RAND_CYCLES = 2000;
    localparam int  DIR_CYCLES  = 60;   // directed tests with their drains
    localparam int  MARGIN      = 100;

    logic            clk;
    logic            rst_n;
    logic            inst1_valid;
    logic            inst1_rd_we;
    logic            inst2_valid;
    logic            inst2_rd_we;
    reg_addr_t       inst1_rd;
    reg_addr_t       inst1_rs1;
    reg_addr_t       inst1_rs2;
    reg_addr_t       inst2_rd;
    reg_addr_t       inst2_rs1;
    reg_addr_t       inst2_rs2;
    exu_type_t       inst1_exu_type;
    exu_type_t       inst2_exu_type;
    logic            commit1_valid;
    logic            commit2_valid;
    logic [ID_W-1:0] commit1_id;
    logic [ID_W-1:0] commit2_id;
    logic [ID_W-1:0] inst1_commit_id;
    logic [ID_W-1:0] inst2_commit_id;
    logic            inst1_jump;
    logic            inst1_branch;
    logic            irq_req;
    logic            long_busy;
    logic [1:0]      issue;

    // reference scoreboard
    logic [NUM_SLOTS-1:0] m_valid;
    reg_addr_t            m_rd [NUM_SLOTS];
    exu_type_t            m_type [NUM_SLOTS];

    logic [1:0]      exp_issue;
    logic [ID_W-1:0] exp_id1;
    logic [ID_W-1:0] exp_id2;
    logic            exp_lock;
    logic            exp_w1;
    logic            exp_w2;
    integer          seed;
    int              n_checks;
    int              n_errors;
    int              test_err_base;

    hdu_top #(.NUM_SLOTS(NUM_SLOTS)) u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst1_valid_i     (inst1_valid),
        .inst1_rd_i        (inst1_rd),
        .inst1_rs1_i       (inst1_rs1),
        .inst1_rs2_i       (inst1_rs2),
        .inst1_rd_we_i     (inst1_rd_we),
        .inst1_exu_type_i  (inst1_exu_type),
        .inst2_valid_i     (inst2_valid),
        .inst2_rd_i        (inst2_rd),
        .inst2_rs1_i       (inst2_rs1),
        .inst2_rs2_i       (inst2_rs2),
        .inst2_rd_we_i     (inst2_rd_we),
        .inst2_exu_type_i  (inst2_exu_type),
        .commit1_valid_i   (commit1_valid),
        .commit1_id_i      (commit1_id),
        .commit2_valid_i   (commit2_valid),
        .commit2_id_i      (commit2_id),
        .inst1_jump_i      (inst1_jump),
        .inst1_branch_i    (inst1_branch),
        .irq_req_i         (irq_req),
        .issue_o           (issue),
        .inst1_commit_id_o (inst1_commit_id),
        .inst2_commit_id_o (inst2_commit_id),
        .long_busy_o       (long_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RST_CYCLES + RAND_CYCLES + DIR_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("Errors found");
        $finish;
    end

    function automatic int rnd(int n);
        return {$random(seed)} % n;
    endfunction

    // RAW on sources or WAW across units for one live slot
    function automatic logic slot_hit(logic v, reg_addr_t rs1, reg_addr_t rs2, logic w,
                                      reg_addr_t rd, exu_type_t typ, int s);
        return (v && rs1 != 0 && rs1 == m_rd[s]) || (v && rs2 != 0 && rs2 == m_rd[s])
            || (w && rd == m_rd[s] && typ != m_type[s]);
    endfunction

    function automatic int count_free();
        int n;
        n = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (!m_valid[s]) n++;
        end
        return n;
    endfunction

    task automatic expect_val(string name, logic [31:0] got, logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic set_inst(int which, logic v, reg_addr_t rd, reg_addr_t rs1,
                            reg_addr_t rs2, logic we, exu_type_t typ);
        if (which == 1) begin
            inst1_valid    = v;
            inst1_rd       = rd;
            inst1_rs1      = rs1;
            inst1_rs2      = rs2;
            inst1_rd_we    = we;
            inst1_exu_type = typ;
        end else begin
            inst2_valid    = v;
            inst2_rd       = rd;
            inst2_rs1      = rs1;
            inst2_rs2      = rs2;
            inst2_rd_we    = we;
            inst2_exu_type = typ;
        end
    endtask

    task automatic idle();
        set_inst(1, 0, 0, 0, 0, 0, EXU_ALU);
        set_inst(2, 0, 0, 0, 0, 0, EXU_ALU);
        commit1_valid = 0;
        commit1_id    = '0;
        commit2_valid = 0;
        commit2_id    = '0;
        inst1_jump    = 0;
        inst1_branch  = 0;
        irq_req       = 0;
    endtask

    task automatic rand_inputs();
        int c;
        set_inst(1, rnd(10) != 0, rnd(8), rnd(8), rnd(8), rnd(5) < 3, exu_type_t'(rnd(4)));
        set_inst(2, rnd(10) != 0, rnd(8), rnd(8), rnd(8), rnd(5) < 3, exu_type_t'(rnd(4)));
        inst1_jump   = rnd(10) == 0;
        inst1_branch = rnd(10) == 0;
        irq_req      = rnd(20) == 0;
        c = rnd(NUM_SLOTS);
        commit1_valid = m_valid[c] && rnd(2);
        commit1_id    = ID_W'(c);
        c = rnd(NUM_SLOTS);
        commit2_valid = m_valid[c] && rnd(2) && !(commit1_valid && commit1_id == ID_W'(c));
        commit2_id    = ID_W'(c);
    endtask

    task automatic predict();
        logic live;
        logic hz1;
        logic hz2;
        logic dep;
        int   nfree;
        int   f1;
        int   f2;
        hz1   = 0;
        hz2   = 0;
        nfree = 0;
        f1    = 0;
        f2    = 0;
        exp_w1 = inst1_valid && inst1_rd_we && inst1_rd != 0;
        exp_w2 = inst2_valid && inst2_rd_we && inst2_rd != 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            live = m_valid[s] && !(commit1_valid && commit1_id == s)
                   && !(commit2_valid && commit2_id == s);
            if (live && slot_hit(inst1_valid, inst1_rs1, inst1_rs2, exp_w1, inst1_rd,
                                 inst1_exu_type, s)) hz1 = 1;
            if (live && slot_hit(inst2_valid, inst2_rs1, inst2_rs2, exp_w2, inst2_rd,
                                 inst2_exu_type, s)) hz2 = 1;
            if (!m_valid[s]) begin
                if (nfree == 0) f1 = s;
                else if (nfree == 1) f2 = s;
                nfree++;
            end
        end
        dep = exp_w1 && ((inst2_valid && inst2_rs1 != 0 && inst2_rs1 == inst1_rd)
                      || (inst2_valid && inst2_rs2 != 0 && inst2_rs2 == inst1_rd)
                      || (exp_w2 && inst2_rd == inst1_rd));
        if (nfree < 2 || irq_req || hz1) exp_issue = 2'b00;
        else if (inst1_jump || inst1_branch || hz2 || dep) exp_issue = 2'b01;
        else exp_issue = 2'b11;
        exp_id1  = (exp_issue[0] && inst1_valid) ? ID_W'(f1) : '0;
        exp_id2  = (exp_issue[1] && inst2_valid) ? ID_W'(f2) : '0;
        exp_lock = |m_valid;
    endtask

    // entered 0.5 ns after an edge and checks 0.5 ns before the next one
    task automatic sample();
        #3.0;
        predict();
        expect_val("issue_o", issue, exp_issue);
        expect_val("inst1_commit_id_o", inst1_commit_id, exp_id1);
        expect_val("inst2_commit_id_o", inst2_commit_id, exp_id2);
        expect_val("long_busy_o", long_busy, exp_lock);
    endtask

    task automatic advance();
        @(posedge clk);
        if (commit1_valid) m_valid[commit1_id] = 1'b0;
        if (commit2_valid) m_valid[commit2_id] = 1'b0;
        if (exp_issue[0] && exp_w1) begin
            m_valid[exp_id1] = 1'b1;
            m_rd[exp_id1]    = inst1_rd;
            m_type[exp_id1]  = inst1_exu_type;
        end
        if (exp_issue[1] && exp_w2) begin
            m_valid[exp_id2] = 1'b1;
            m_rd[exp_id2]    = inst2_rd;
            m_type[exp_id2]  = inst2_exu_type;
        end
        #0.5;
    endtask

    task automatic cycle();
        sample();
        advance();
    endtask

    // retire everything in flight with two commits per cycle
    task automatic drain();
        idle();
        while (|m_valid) begin
            commit1_valid = 0;
            commit2_valid = 0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (m_valid[s] && !commit1_valid) begin
                    commit1_valid = 1;
                    commit1_id    = ID_W'(s);
                end else if (m_valid[s] && !commit2_valid) begin
                    commit2_valid = 1;
                    commit2_id    = ID_W'(s);
                end
            end
            cycle();
        end
        idle();
    endtask

    task automatic test_done(string name);
        if (n_errors == test_err_base) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - test_err_base);
        end
        test_err_base = n_errors;
    endtask

    initial begin
        int              r;
        logic [ID_W-1:0] held;
        seed          = 93674;
        n_checks      = 0;
        n_errors      = 0;
        test_err_base = 0;
        m_valid       = '0;
        rst_n         = 1'b0;
        idle();
        repeat (RST_CYCLES) @(posedge clk);
        #0.5 rst_n = 1'b1;

        set_inst(1, 1, 0, 3, 4, 0, EXU_ALU);
        set_inst(2, 1, 0, 5, 6, 0, EXU_ALU);
        sample();
        expect_val("long_busy_o", long_busy, 0);
        expect_val("issue_o", issue, 2'b11);
        expect_val("inst1_commit_id_o", inst1_commit_id, 0);
        expect_val("inst2_commit_id_o", inst2_commit_id, 1);
        advance();
        test_done("after reset");

        repeat (RAND_CYCLES) begin
            rand_inputs();
            cycle();
        end
        test_done("random traffic");

        drain();
        set_inst(1, 1, 0, 1, 2, 0, EXU_ALU);
        set_inst(2, 1, 0, 3, 4, 0, EXU_ALU);
        for (int k = 0; k < 2; k++) begin
            inst1_jump   = (k == 0);
            inst1_branch = (k == 1);
            sample();
            expect_val("issue_o", issue, 2'b01);
            expect_val("inst2_commit_id_o", inst2_commit_id, 0);
            advance();
        end
        test_done("jump and branch");

        drain();
        set_inst(1, 1, 0, 1, 2, 0, EXU_ALU);
        irq_req = 1;
        sample();
        expect_val("issue_o", issue, 2'b00);
        advance();
        irq_req = 0;
        set_inst(1, 1, 5, 0, 0, 1, EXU_MUL);
        cycle();
        set_inst(1, 1, 0, 5, 0, 0, EXU_ALU);  // raw on x5
        sample();
        expect_val("issue_o", issue, 2'b00);
        advance();
        set_inst(1, 1, 5, 0, 0, 1, EXU_DIV);  // waw from another unit
        sample();
        expect_val("issue_o", issue, 2'b00);
        advance();
        set_inst(1, 1, 5, 0, 0, 1, EXU_MUL);
        sample();
        expect_val("issue_o[0]", issue[0], 1);
        advance();
        test_done("interrupt and inst1 hazards");

        drain();
        set_inst(1, 1, 7, 0, 0, 1, EXU_DIV);
        cycle();
        held = exp_id1;  // slot now waiting on x7
        set_inst(1, 1, 0, 0, 7, 0, EXU_ALU);
        sample();
        expect_val("issue_o", issue, 2'b00);
        advance();
        commit1_valid = 1;
        commit1_id    = held;
        sample();
        expect_val("issue_o[0]", issue[0], 1);
        advance();
        test_done("commit clears hazard");

        drain();
        r = 1;
        while (count_free() >= 2) begin
            set_inst(1, 1, r, 0, 0, 1, EXU_ALU);
            set_inst(2, 1, r + 1, 0, 0, 1, EXU_ALU);
            r += 2;
            cycle();
        end
        sample();
        expect_val("issue_o", issue, 2'b00);
        expect_val("long_busy_o", long_busy, 1);
        advance();
        drain();
        sample();
        expect_val("long_busy_o", long_busy, 0);
        advance();
        test_done("scoreboard full");

        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hw/hdu_pkg.sv
hw/hdu_scoreboard.sv
hw/hdu_slot_alloc.sv
hw/hdu_hazard_check.sv
hw/hdu_issue_ctrl.sv
hw/hdu_top.sv
tb/tb_hdu.sv

// File: Bender.yml
package:
  name: hdu

sources:
  - hw/hdu_pkg.sv
  - hw/hdu_scoreboard.sv
  - hw/hdu_slot_alloc.sv
  - hw/hdu_hazard_check.sv
  - hw/hdu_issue_ctrl.sv
  - hw/hdu_top.sv
  - target: simulation
    files:
      - tb/tb_hdu.sv
